//--- trigEffPkg.sv
package trigEffPkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and constants
    //////////////////////////////////////////////////////////////////////

    // Counts and output words
    localparam int CountWidth = 16;

    // Trigger window length setting
    localparam int DelayWidth = 4;

    // First word of every test
    localparam logic [CountWidth-1:0] HeaderWord = 16'h4343;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    // Result of one channel, pulses in the upper half
    typedef struct packed {
        logic [CountWidth-1:0] pulses;
        logic [CountWidth-1:0] triggers;
    } channelCountT;

    // Settings of one test
    typedef struct packed {
        logic [CountWidth-1:0] cptMax;
        logic [DelayWidth-1:0] triggerDelay;
    } testConfigT;

    // Sequencer states
    typedef enum logic [2:0] {
        Idle,
        Header,
        Arm,
        Run,
        Capture,
        Send,
        Finished
    } testStateT;

endpackage

//--- inputSync.sv
`timescale 1ns/10ps

module inputSync #(
    parameter bit FallingEdge = 1'b0
) (
    input  logic Clk,
    input  logic reset_n,
    input  logic raw,
    output logic edgeEvent
);

    logic syncMeta;
    logic syncStable;
    logic syncLast;

    // Flops start at the idle level of the line so reset gives no false edge
    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            syncMeta   <= FallingEdge;
            syncStable <= FallingEdge;
            syncLast   <= FallingEdge;
        end else begin
            syncMeta   <= raw;
            syncStable <= syncMeta;
            syncLast   <= syncStable;
        end
    end

    // One-cycle strobe on the selected edge
    always_comb begin
        if (FallingEdge) begin
            edgeEvent = syncLast && !syncStable;
        end else begin
            edgeEvent = syncStable && !syncLast;
        end
    end

endmodule

//--- channelCounter.sv
`timescale 1ns/10ps

module channelCounter #(
    parameter int CountWidth = trigEffPkg::CountWidth
) (
    input  logic                     Clk,
    input  logic                     reset_n,
    input  trigEffPkg::testConfigT   cfg,
    input  logic                     clear,
    input  logic                     armed,
    input  logic                     pulseEvent,
    input  logic                     trigEvent,
    output trigEffPkg::channelCountT count,
    output logic                     done
);

    import trigEffPkg::*;

    logic [CountWidth-1:0] pulses;
    logic [CountWidth-1:0] triggers;
    logic [DelayWidth-1:0] windowCnt;
    logic                  windowOpen;
    logic                  trigSeen;
    logic                  lastPulseSeen;
    logic                  acceptPulse;
    logic                  trigHit;

    //////////////////////////////////////////////////////////////////////
    // Window decode
    //////////////////////////////////////////////////////////////////////

    assign lastPulseSeen = (pulses == cfg.cptMax);

    // Pulses past cptMax are dropped
    assign acceptPulse = armed && pulseEvent && !lastPulseSeen;

    // The pulse cycle itself belongs to the window, and a new pulse
    // starts with no trigger seen yet
    assign trigHit = trigEvent && (acceptPulse || (windowOpen && !trigSeen));

    //////////////////////////////////////////////////////////////////////
    // Counters
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            pulses     <= '0;
            triggers   <= '0;
            windowCnt  <= '0;
            windowOpen <= 1'b0;
            trigSeen   <= 1'b0;
            done       <= 1'b0;
        end else if (clear) begin
            pulses     <= '0;
            triggers   <= '0;
            windowCnt  <= '0;
            windowOpen <= 1'b0;
            trigSeen   <= 1'b0;
            done       <= 1'b0;
        end else begin
            if (acceptPulse) begin
                pulses     <= pulses + 1'b1;
                windowCnt  <= cfg.triggerDelay;
                windowOpen <= (cfg.triggerDelay != '0);
                trigSeen   <= trigEvent;
            end else if (windowOpen) begin
                // Open for triggerDelay cycles after the pulse cycle
                windowCnt  <= windowCnt - 1'b1;
                windowOpen <= (windowCnt != DelayWidth'(1));
                trigSeen   <= trigSeen || trigEvent;
            end

            if (trigHit) begin
                triggers <= triggers + 1'b1;
            end

            // Sticky until the next clear
            if (armed && lastPulseSeen && !windowOpen) begin
                done <= 1'b1;
            end
        end
    end

    assign count.pulses   = pulses;
    assign count.triggers = triggers;

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // At most one trigger per accepted pulse
    assert property (@(posedge Clk) disable iff (!reset_n) triggers <= pulses)
        else $error("channelCounter: triggers %0d above pulses %0d", triggers, pulses);

    // Counts of the last test stay until the next clear, while cfg may already change
    assert property (@(posedge Clk) disable iff (!reset_n) armed |-> pulses <= cfg.cptMax)
        else $error("channelCounter: pulses %0d above cptMax %0d", pulses, cfg.cptMax);

endmodule

//--- trigEfficiencyTest.sv
`timescale 1ns/10ps

module trigEfficiencyTest #(
    parameter int NumChannels = 3,
    parameter int CountWidth  = trigEffPkg::CountWidth
) (
    input  logic                     Clk,
    input  logic                     reset_n,
    input  logic                     start,
    input  trigEffPkg::channelCountT counts [NumChannels],
    input  logic [NumChannels-1:0]   chanDone,
    input  logic                     dataTransmitDone,
    output logic                     clear,
    output logic                     armed,
    output logic [CountWidth-1:0]    dataWord,
    output logic                     dataValid,
    output logic                     testDone
);

    import trigEffPkg::*;

    localparam int NumWords  = 2 * NumChannels;
    localparam int IdxWidth  = $clog2(NumWords + 1);
    localparam int SlotWidth = 2 * CountWidth;
    localparam int ShiftBits = NumWords * CountWidth;

    testStateT             state;
    logic [IdxWidth-1:0]   wordIdx;
    logic [ShiftBits-1:0]  resultShift;
    logic [ShiftBits-1:0]  packedCounts;
    logic                  allDone;
    logic                  startTest;
    logic                  sendingWord;

    assign allDone     = &chanDone;
    assign startTest   = (state == Idle) && start;
    assign sendingWord = (state == Send) && (wordIdx != IdxWidth'(NumWords));

    // Channel 0 goes to the top so it leaves the shift register first
    always_comb begin
        packedCounts = '0;
        for (int ch = 0; ch < NumChannels; ch++) begin
            packedCounts[(NumChannels-1-ch)*SlotWidth +: SlotWidth] = counts[ch];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Sequencer FSM
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk or negedge reset_n) begin
        if (!reset_n) begin
            state     <= Idle;
            wordIdx   <= '0;
            clear     <= 1'b0;
            armed     <= 1'b0;
            dataValid <= 1'b0;
            testDone  <= 1'b0;
        end else begin
            case (state)
                Idle: begin
                    if (start) begin
                        // Header word and counter clear go out together
                        dataValid <= 1'b1;
                        clear     <= 1'b1;
                        state     <= Header;
                    end
                end

                Header: begin
                    dataValid <= 1'b0;
                    clear     <= 1'b0;
                    armed     <= 1'b1;
                    state     <= Arm;
                end

                // One cycle for done to settle after the clear
                Arm: begin
                    state <= Run;
                end

                Run: begin
                    if (allDone) begin
                        armed <= 1'b0;
                        state <= Capture;
                    end
                end

                Capture: begin
                    wordIdx <= '0;
                    state   <= Send;
                end

                Send: begin
                    if (sendingWord) begin
                        dataValid <= 1'b1;
                        wordIdx   <= wordIdx + 1'b1;
                    end else begin
                        dataValid <= 1'b0;
                        testDone  <= 1'b1;
                        state     <= Finished;
                    end
                end

                Finished: begin
                    if (dataTransmitDone) begin
                        testDone <= 1'b0;
                        state    <= Idle;
                    end
                end

                default: begin
                    state <= Idle;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Output word path
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge Clk) begin
        if (startTest) begin
            dataWord <= HeaderWord;
        end else if (sendingWord) begin
            dataWord <= resultShift[ShiftBits-1 -: CountWidth];
        end

        if (state == Capture) begin
            resultShift <= packedCounts;
        end else if (sendingWord) begin
            resultShift <= resultShift << CountWidth;
        end
    end

    // Words only go out between start and testDone
    assert property (@(posedge Clk) disable iff (!reset_n)
        (state == Finished || state == Idle) |-> !dataValid)
        else $error("trigEfficiencyTest: dataValid high in state %s", state.name());

endmodule

//--- trigEffTop.sv
`timescale 1ns/10ps

module trigEffTop #(
    parameter int NumChannels = 3,
    parameter int CountWidth  = trigEffPkg::CountWidth
) (
    input  logic                   Clk,
    input  logic                   reset_n,
    input  logic                   CLK_EXT,
    input  logic [NumChannels-1:0] triggerB,
    input  logic                   start,
    input  trigEffPkg::testConfigT cfg,
    input  logic                   dataTransmitDone,
    output logic [CountWidth-1:0]  dataWord,
    output logic                   dataValid,
    output logic                   testDone
);

    import trigEffPkg::*;

    logic                   pulseEvent;
    logic [NumChannels-1:0] trigEvent;
    logic [NumChannels-1:0] chanDone;
    logic                   clear;
    logic                   armed;
    channelCountT           counts [NumChannels];

    // Test pulse is shared by all channels
    inputSync #(
        .FallingEdge(1'b0)
    ) pulseSync (
        .Clk      (Clk),
        .reset_n  (reset_n),
        .raw      (CLK_EXT),
        .edgeEvent(pulseEvent)
    );

    //////////////////////////////////////////////////////////////////////
    // Per-channel trigger path
    //////////////////////////////////////////////////////////////////////

    for (genvar ch = 0; ch < NumChannels; ch++) begin : gChannel
        // Triggers are active low
        inputSync #(
            .FallingEdge(1'b1)
        ) trigSync (
            .Clk      (Clk),
            .reset_n  (reset_n),
            .raw      (triggerB[ch]),
            .edgeEvent(trigEvent[ch])
        );

        channelCounter #(
            .CountWidth(CountWidth)
        ) counter (
            .Clk       (Clk),
            .reset_n   (reset_n),
            .cfg       (cfg),
            .clear     (clear),
            .armed     (armed),
            .pulseEvent(pulseEvent),
            .trigEvent (trigEvent[ch]),
            .count     (counts[ch]),
            .done      (chanDone[ch])
        );
    end

    trigEfficiencyTest #(
        .NumChannels(NumChannels),
        .CountWidth (CountWidth)
    ) sequencer (
        .Clk             (Clk),
        .reset_n         (reset_n),
        .start           (start),
        .counts          (counts),
        .chanDone        (chanDone),
        .dataTransmitDone(dataTransmitDone),
        .clear           (clear),
        .armed           (armed),
        .dataWord        (dataWord),
        .dataValid       (dataValid),
        .testDone        (testDone)
    );

endmodule

//--- tbTrigEff.sv
`timescale 1ns/10ps

module tbTrigEff;

    import trigEffPkg::*;

    localparam int NumChannels   = 3;
    localparam int ClkPeriod     = 40;
    localparam int NumTests      = 8;
    localparam int MaxCpt        = 40;
    localparam int PulseSpacing  = 24;
    localparam int PulseHigh     = 4;
    localparam int ScheduleLen   = MaxCpt * PulseSpacing + PulseSpacing;
    localparam int DoneTimeout   = 200;
    localparam int WatchdogCycles = NumTests * (ScheduleLen + 300) + 100;

    logic                   Clk;
    logic                   reset_n;
    logic                   CLK_EXT;
    logic [NumChannels-1:0] triggerB;
    logic                   start;
    testConfigT             cfg;
    logic                   dataTransmitDone;
    logic [CountWidth-1:0]  dataWord;
    logic                   dataValid;
    logic                   testDone;

    logic [31:0]            rngState;
    logic [CountWidth-1:0]  words [$];
    logic [NumChannels-1:0] lowAt [ScheduleLen];
    int                     errorCount;
    int                     passCount;
    int                     failCount;

    trigEffTop #(
        .NumChannels(NumChannels)
    ) dut (
        .Clk             (Clk),
        .reset_n         (reset_n),
        .CLK_EXT         (CLK_EXT),
        .triggerB        (triggerB),
        .start           (start),
        .cfg             (cfg),
        .dataTransmitDone(dataTransmitDone),
        .dataWord        (dataWord),
        .dataValid       (dataValid),
        .testDone        (testDone)
    );

    always #(ClkPeriod / 2) Clk = ~Clk;

    // Word collector, sampled away from the active edge
    always @(negedge Clk) begin
        if (reset_n && dataValid) begin
            words.push_back(dataWord);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int nextRand(input int range);
        rngState = xorshift32(rngState);
        return int'(rngState % 32'(range));
    endfunction

    task automatic checkValue(input string name, input int expected, input int actual);
        if (expected != actual) begin
            $display("** Error %s: expected %0d, actual %0d", name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic noteFailure(input string msg);
        $display("%s", msg);
        errorCount++;
    endtask

    task automatic checkIdleAfterReset();
        int errorsBefore;
        errorsBefore = errorCount;
        repeat (10) begin
            @(negedge Clk);
            if (dataValid || testDone) begin
                noteFailure("reset: dataValid or testDone high before any start");
            end
        end
        if (errorCount == errorsBefore) begin
            passCount++;
            $display("reset idle check: ok");
        end else begin
            failCount++;
            $display("reset idle check: FAILED");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One complete test with its own model
    //////////////////////////////////////////////////////////////////////

    task automatic runTest(input int testIdx);
        int    cpt;
        int    dly;
        int    kind;
        int    offset;
        int    sel;
        int    errorsBefore;
        int    waited;
        int    expTrig [NumChannels];
        string name;
        errorsBefore = errorCount;
        name = $sformatf("test%0d", testIdx);
        cpt = 1 + nextRand(MaxCpt);
        dly = nextRand(16);
        for (int c = 0; c < ScheduleLen; c++) begin
            lowAt[c] = '0;
        end

        // Trigger plan per pulse and channel, window edges favoured
        for (int ch = 0; ch < NumChannels; ch++) begin
            expTrig[ch] = 0;
        end
        for (int p = 0; p < cpt; p++) begin
            for (int ch = 0; ch < NumChannels; ch++) begin
                kind = nextRand(3);
                sel = nextRand(4);
                if (sel == 0) begin
                    offset = dly;
                end else if (sel == 1) begin
                    offset = dly + 1;
                end else begin
                    offset = nextRand(21);
                end
                if (kind != 0) begin
                    lowAt[p * PulseSpacing + offset][ch] = 1'b1;
                    if (offset <= dly) begin
                        expTrig[ch]++;
                    end
                end
                if (kind == 2) begin
                    lowAt[p * PulseSpacing + offset + 2][ch] = 1'b1;
                end
            end
        end

        words.delete();
        @(posedge Clk);
        cfg.cptMax       <= CountWidth'(cpt);
        cfg.triggerDelay <= DelayWidth'(dly);
        @(posedge Clk);
        start <= 1'b1;
        @(posedge Clk);
        start <= 1'b0;

        waited = 0;
        do begin
            @(negedge Clk);
            waited++;
        end while (!dataValid && waited < 10);
        if (!dataValid) begin
            noteFailure($sformatf("%s: no header word after start", name));
        end

        // Pulse train and trigger lines, one step per clock
        for (int c = 0; c < cpt * PulseSpacing + PulseSpacing; c++) begin
            @(posedge Clk);
            CLK_EXT  <= (c < cpt * PulseSpacing) && ((c % PulseSpacing) < PulseHigh);
            triggerB <= ~lowAt[c];
        end
        @(posedge Clk);
        CLK_EXT  <= 1'b0;
        triggerB <= '1;

        waited = 0;
        while (!testDone && waited < DoneTimeout) begin
            @(negedge Clk);
            waited++;
        end
        if (!testDone) begin
            noteFailure($sformatf("%s: testDone never rose", name));
        end
        @(posedge Clk);

        checkValue({name, " word count"}, 1 + 2 * NumChannels, words.size());
        if (words.size() >= 1 && words[0] != 16'h4343) begin
            $display("** Error %s header: expected 'h4343, actual 'h%h", name, words[0]);
            errorCount++;
        end
        if (words.size() == 1 + 2 * NumChannels) begin
            for (int ch = 0; ch < NumChannels; ch++) begin
                checkValue($sformatf("%s ch%0d pulses", name, ch), cpt,
                    int'(words[1 + 2 * ch]));
                checkValue($sformatf("%s ch%0d triggers", name, ch), expTrig[ch],
                    int'(words[2 + 2 * ch]));
            end
        end

        // testDone must hold until the link reports completion
        repeat (2 + nextRand(6)) begin
            @(negedge Clk);
            if (!testDone) begin
                noteFailure($sformatf("%s: testDone fell before dataTransmitDone", name));
            end
        end
        @(posedge Clk);
        dataTransmitDone <= 1'b1;
        @(posedge Clk);
        dataTransmitDone <= 1'b0;
        @(negedge Clk);
        if (testDone) begin
            noteFailure($sformatf("%s: testDone still high after dataTransmitDone", name));
        end
        if (words.size() > 1 + 2 * NumChannels) begin
            noteFailure($sformatf("%s: extra words arrived after testDone", name));
        end

        if (errorCount == errorsBefore) begin
            passCount++;
        end else begin
            failCount++;
        end
        $display("%s cptMax=%0d delay=%0d triggers %0d %0d %0d: %s", name, cpt, dly,
            expTrig[0], expTrig[1], expTrig[2], (errorCount == errorsBefore) ? "ok" : "FAILED");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial begin
        Clk              = 1'b0;
        reset_n          = 1'b0;
        CLK_EXT          = 1'b0;
        triggerB         = '1;
        start            = 1'b0;
        cfg              = '0;
        dataTransmitDone = 1'b0;
        rngState         = 32'h7dbb5282;
        errorCount       = 0;
        passCount        = 0;
        failCount        = 0;

        repeat (2) @(posedge Clk);
        reset_n <= 1'b1;

        checkIdleAfterReset();
        for (int t = 0; t < NumTests; t++) begin
            runTest(t);
        end

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
            passCount + failCount, passCount, failCount, errorCount);
        if (errorCount == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("Watchdog expired after %0d cycles, the run did not complete", WatchdogCycles);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- flist.f
trigEffPkg.sv
inputSync.sv
channelCounter.sv
trigEfficiencyTest.sv
trigEffTop.sv
tbTrigEff.sv

//--- run.sh
#!/bin/sh
# Build and run the trigger efficiency testbench with Verilator
verilator --binary --timing --timescale 1ns/10ps -f flist.f \
    --top-module tbTrigEff -o simTrigEff \
    && ./obj_dir/simTrigEff > sim.log \
    ; cat sim.log 2>/dev/null \
    ; grep -q "^Regression passed$" sim.log \
    && echo "run.sh: simulation PASS" \
    || { echo "run.sh: simulation FAIL"; exit 1; }
